// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_rv_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/core_cfg_if.sv
`timescale 1ns/1ps

interface core_cfg_if import rv_pkg::*; ();
    logic  start;      // one-cycle pulse
    logic  run;
    word_t init_pc;
    word_t mem_offset;
    logic  store_fire;
    word_t store_data;

    modport ctrl (
        output start, run, init_pc, mem_offset,
        input  store_fire, store_data
    );

    modport core (
        input  start, run, init_pc, mem_offset,
        output store_fire, store_data
    );
endinterface

// File: design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
    input  word_t    instr_i,
    output opcode_e  opcode_o,
    output alu_op_e  alu_op_o,
    output reg_idx_t rd_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output word_t    imm_o,
    output logic     reg_write_o,
    output logic     use_imm_o,
    output logic     branch_ne_o
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign funct3      = instr_i[14:12];
    assign funct7      = instr_i[31:25];
    assign rd_o        = instr_i[11:7];
    assign rs1_o       = instr_i[19:15];
    assign rs2_o       = instr_i[24:20];
    assign branch_ne_o = funct3[0];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        opcode_o    = op_imm; // anything unsupported ends up a non-writing addi
        alu_op_o    = alu_add;
        imm_o       = imm_i;
        reg_write_o = 1'b0;
        use_imm_o   = 1'b1;
        case (instr_i[6:0])
            op_reg: begin
                use_imm_o = 1'b0;
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    opcode_o    = op_reg;
                    reg_write_o = 1'b1;
                    case (funct3)
                        3'b000:  alu_op_o = funct7[5] ? alu_sub : alu_add;
                        3'b100:  alu_op_o = alu_xor;
                        3'b110:  alu_op_o = alu_or;
                        3'b111:  alu_op_o = alu_and;
                        default: reg_write_o = 1'b0; // shifts, compares
                    endcase
                end
            end
            op_imm: begin
                reg_write_o = (funct3 == 3'b000); // addi only
            end
            op_lui: begin
                opcode_o    = op_lui;
                alu_op_o    = alu_pass_b;
                imm_o       = imm_u;
                reg_write_o = 1'b1;
            end
            op_load: begin
                if (funct3 == 3'b010) begin
                    opcode_o    = op_load;
                    reg_write_o = 1'b1;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    opcode_o = op_store;
                    imm_o    = imm_s;
                end
            end
            op_branch: begin
                if (funct3[2:1] == 2'b00) begin // beq, bne
                    opcode_o  = op_branch;
                    imm_o     = imm_b;
                    use_imm_o = 1'b0;
                end
            end
            op_jal: begin
                opcode_o    = op_jal;
                imm_o       = imm_j;
                reg_write_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
    input  word_t    pc_i,
    input  opcode_e  opcode_i,
    input  alu_op_e  alu_op_i,
    input  logic     use_imm_i,
    input  logic     branch_ne_i,
    input  word_t    imm_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  word_t    rdata1_i,
    input  word_t    rdata2_i,
    input  reg_idx_t mem_rd_i,
    input  logic     mem_wr_i,
    input  word_t    mem_result_i,
    input  reg_idx_t wb_rd_i,
    input  logic     wb_wr_i,
    input  word_t    wb_result_i,
    output word_t    result_o,
    output word_t    store_data_o,
    output logic     redirect_o,
    output word_t    target_o
);
    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_out;
    logic  equal;

    // memory stage is younger than write-back, so it wins
    function automatic word_t fwd(reg_idx_t src, word_t rf_val);
        if (src != '0 && mem_wr_i && mem_rd_i == src)
            return mem_result_i;
        if (src != '0 && wb_wr_i && wb_rd_i == src)
            return wb_result_i;
        return rf_val;
    endfunction

    always_comb begin
        op_a     = fwd(rs1_i, rdata1_i);
        op_b_reg = fwd(rs2_i, rdata2_i);
    end

    assign op_b = use_imm_i ? imm_i : op_b_reg;

    always_comb begin
        case (alu_op_i)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    assign equal        = (op_a == op_b_reg);
    assign result_o     = (opcode_i == op_jal) ? pc_i + 32'd4 : alu_out; // link value
    assign store_data_o = op_b_reg;
    assign target_o     = pc_i + imm_i;
    assign redirect_o   = (opcode_i == op_jal) ||
                          (opcode_i == op_branch && (equal ^ branch_ne_i));

endmodule

// File: design/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    core_cfg_if.core cfg,
    output word_t    imem_addr_o,
    input  word_t    imem_rdata_i,
    output word_t    dmem_addr_o,
    output logic     dmem_we_o,
    output logic     dmem_re_o,
    output word_t    dmem_wdata_o,
    input  word_t    dmem_rdata_i
);
    word_t    pc;
    word_t    fd_pc;
    word_t    fd_instr;
    opcode_e  dec_opcode;
    alu_op_e  dec_alu_op;
    reg_idx_t dec_rd;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    word_t    dec_imm;
    logic     dec_wr;
    logic     dec_use_imm;
    logic     dec_branch_ne;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    de_pc;
    opcode_e  de_opcode;
    alu_op_e  de_alu_op;
    reg_idx_t de_rd;
    reg_idx_t de_rs1;
    reg_idx_t de_rs2;
    word_t    de_imm;
    logic     de_wr;
    logic     de_use_imm;
    logic     de_branch_ne;
    word_t    de_rdata1;
    word_t    de_rdata2;
    word_t    ex_result;
    word_t    ex_store_data;
    logic     ex_redirect;
    word_t    ex_target;
    logic     flush;
    opcode_e  em_opcode;
    reg_idx_t em_rd;
    logic     em_wr;
    word_t    em_result;
    word_t    em_store_data;
    word_t    mem_result;
    reg_idx_t mw_rd;
    logic     mw_wr;
    word_t    mw_result;

    decode_unit decode_unit_i (
        .instr_i     (fd_instr),
        .opcode_o    (dec_opcode),
        .alu_op_o    (dec_alu_op),
        .rd_o        (dec_rd),
        .rs1_o       (dec_rs1),
        .rs2_o       (dec_rs2),
        .imm_o       (dec_imm),
        .reg_write_o (dec_wr),
        .use_imm_o   (dec_use_imm),
        .branch_ne_o (dec_branch_ne)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_i    (dec_rs1),
        .rs2_i    (dec_rs2),
        .we_i     (mw_wr & cfg.run),
        .rd_i     (mw_rd),
        .wdata_i  (mw_result),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    execute_unit execute_unit_i (
        .pc_i         (de_pc),
        .opcode_i     (de_opcode),
        .alu_op_i     (de_alu_op),
        .use_imm_i    (de_use_imm),
        .branch_ne_i  (de_branch_ne),
        .imm_i        (de_imm),
        .rs1_i        (de_rs1),
        .rs2_i        (de_rs2),
        .rdata1_i     (de_rdata1),
        .rdata2_i     (de_rdata2),
        .mem_rd_i     (em_rd),
        .mem_wr_i     (em_wr),
        .mem_result_i (mem_result),
        .wb_rd_i      (mw_rd),
        .wb_wr_i      (mw_wr),
        .wb_result_i  (mw_result),
        .result_o     (ex_result),
        .store_data_o (ex_store_data),
        .redirect_o   (ex_redirect),
        .target_o     (ex_target)
    );

    assign flush = cfg.run & ex_redirect; // kills fetch and decode

    // start reloads the pc and refills every stage with bubbles
    always_ff @(posedge clk) begin
        if (reset || cfg.start) begin
            pc        <= cfg.init_pc;
            fd_instr  <= nop_instr;
            de_opcode <= op_imm;
            de_wr     <= 1'b0;
            em_opcode <= op_imm;
            em_wr     <= 1'b0;
            mw_wr     <= 1'b0;
        end else if (cfg.run) begin
            if (flush) begin
                pc        <= ex_target;
                fd_instr  <= nop_instr;
                de_opcode <= op_imm;
                de_wr     <= 1'b0;
            end else begin
                pc        <= pc + 32'd4;
                fd_instr  <= imem_rdata_i;
                de_opcode <= dec_opcode;
                de_wr     <= dec_wr;
            end
            em_opcode <= de_opcode;
            em_wr     <= de_wr;
            mw_wr     <= em_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.run) begin
            fd_pc         <= pc;
            de_pc         <= fd_pc;
            de_alu_op     <= dec_alu_op;
            de_rd         <= dec_rd;
            de_rs1        <= dec_rs1;
            de_rs2        <= dec_rs2;
            de_imm        <= dec_imm;
            de_use_imm    <= dec_use_imm;
            de_branch_ne  <= dec_branch_ne;
            de_rdata1     <= rf_rdata1;
            de_rdata2     <= rf_rdata2;
            em_rd         <= de_rd;
            em_result     <= ex_result;
            em_store_data <= ex_store_data;
            mw_rd         <= em_rd;
            mw_result     <= mem_result;
        end
    end

    assign imem_addr_o = pc;

    // memory stage
    assign dmem_addr_o    = em_result - cfg.mem_offset;
    assign dmem_wdata_o   = em_store_data;
    assign dmem_we_o      = cfg.run && em_opcode == op_store;
    assign dmem_re_o      = cfg.run && em_opcode == op_load;
    assign mem_result     = (em_opcode == op_load) ? dmem_rdata_i : em_result;
    assign cfg.store_fire = dmem_we_o;
    assign cfg.store_data = em_store_data;

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  logic     we_i,
    input  reg_idx_t rd_i,
    input  word_t    wdata_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);
    word_t regs [1:31]; // x0 not stored

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // write-through covers write-back and decode in the same cycle
    assign rdata1_o = (rs1_i == '0) ? '0 :
                      (we_i && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 :
                      (we_i && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

endmodule

// File: design/run_ctrl_regs.sv
`timescale 1ns/1ps

module run_ctrl_regs import rv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [apb_addr_w-1:0] paddr_i,
    input  word_t                 pwdata_i,
    output word_t                 prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    core_cfg_if.ctrl              cfg
);
    logic  access;
    logic  addr_hit;
    logic  wr_en;
    logic  start_q;
    logic  run_q;
    logic  done_q;
    word_t mem_offset_q;
    word_t init_pc_q;
    word_t success_q;
    word_t cycle_q;
    word_t final_q;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i & addr_hit;

    always_comb begin
        addr_hit = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            reg_ctrl_addr:       prdata_o = '0; // start reads back as 0
            reg_mem_offset_addr: prdata_o = mem_offset_q;
            reg_init_pc_addr:    prdata_o = init_pc_q;
            reg_success_addr:    prdata_o = success_q;
            reg_status_addr:     prdata_o = {30'b0, done_q, run_q};
            reg_cycle_addr:      prdata_o = cycle_q;
            reg_final_addr:      prdata_o = final_q;
            default:             addr_hit = 1'b0;
        endcase
    end

    assign pready_o  = 1'b1; // no wait states
    assign pslverr_o = access & ~addr_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q      <= 1'b0;
            mem_offset_q <= '0;
            init_pc_q    <= reset_pc;
            success_q    <= '0;
        end else begin
            start_q <= wr_en && paddr_i == reg_ctrl_addr && pwdata_i[0];
            if (wr_en) begin
                case (paddr_i)
                    reg_mem_offset_addr: mem_offset_q <= pwdata_i;
                    reg_init_pc_addr:    init_pc_q    <= pwdata_i;
                    reg_success_addr:    success_q    <= pwdata_i;
                    default: ; // read-only or ctrl
                endcase
            end
        end
    end

    // run state and success detection
    always_ff @(posedge clk) begin
        if (reset) begin
            run_q   <= 1'b0;
            done_q  <= 1'b0;
            cycle_q <= '0;
            final_q <= '0;
        end else if (start_q) begin
            run_q   <= 1'b1;
            done_q  <= 1'b0;
            cycle_q <= '0;
            final_q <= '0;
        end else if (run_q) begin
            cycle_q <= cycle_q + 1'b1;
            if (cfg.store_fire) begin
                final_q <= cfg.store_data;
                if (cfg.store_data == success_q) begin
                    done_q <= 1'b1;
                    run_q  <= 1'b0; // stops from next cycle
                end
            end
        end
    end

    assign cfg.start      = start_q;
    assign cfg.run        = run_q;
    assign cfg.init_pc    = init_pc_q;
    assign cfg.mem_offset = mem_offset_q;

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int apb_addr_w = 8;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b // lui
    } alu_op_e;

    // run controller register map
    localparam logic [apb_addr_w-1:0] reg_ctrl_addr       = 8'h00; // bit 0 start
    localparam logic [apb_addr_w-1:0] reg_mem_offset_addr = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_init_pc_addr    = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_success_addr    = 8'h0C;
    localparam logic [apb_addr_w-1:0] reg_status_addr     = 8'h10; // running, done
    localparam logic [apb_addr_w-1:0] reg_cycle_addr      = 8'h14;
    localparam logic [apb_addr_w-1:0] reg_final_addr      = 8'h18; // last store data

    localparam word_t nop_instr = 32'h0000_0013; // addi x0, x0, 0

endpackage

// File: design/rv_top.sv
`timescale 1ns/1ps

module rv_top import rv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [apb_addr_w-1:0] paddr_i,
    input  word_t                 pwdata_i,
    output word_t                 prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output word_t                 imem_addr_o,
    input  word_t                 imem_rdata_i,
    output word_t                 dmem_addr_o,
    output logic                  dmem_we_o,
    output logic                  dmem_re_o,
    output word_t                 dmem_wdata_o,
    input  word_t                 dmem_rdata_i
);
    core_cfg_if core_cfg_if_i ();

    run_ctrl_regs #(
        .reset_pc (reset_pc)
    ) run_ctrl_regs_i (
        .clk       (clk),
        .reset     (reset),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cfg       (core_cfg_if_i.ctrl)
    );

    pipeline_core pipeline_core_i (
        .clk          (clk),
        .reset        (reset),
        .cfg          (core_cfg_if_i.core),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_re_o    (dmem_re_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i)
    );

endmodule

// File: files.f
design/rv_pkg.sv
design/core_cfg_if.sv
design/run_ctrl_regs.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/pipeline_core.sv
design/rv_top.sv
test/tb_rv_top.sv

// File: test/tb_rv_top.sv
`timescale 1ns/1ps

module tb_rv_top import rv_pkg::*; ();
    localparam int clk_period      = 8;
    localparam int num_tests       = 6;
    localparam int cycles_per_test = 200;
    localparam int mem_words       = 256;

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    word_t                 imem_addr;
    word_t                 imem_rdata;
    word_t                 dmem_addr;
    logic                  dmem_we;
    logic                  dmem_re;
    word_t                 dmem_wdata;
    word_t                 dmem_rdata;

    word_t imem [mem_words];
    word_t dmem [mem_words];
    word_t lfsr        = 32'h8432;
    int    load_ptr    = 0;
    int    load_cycles = 0;
    int    errors      = 0;
    int    checks      = 0;

    rv_top rv_top_i (
        .clk          (clk),
        .reset        (reset),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_we_o    (dmem_we),
        .dmem_re_o    (dmem_re),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // both memories answer combinationally
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(negedge clk) begin
        if (dmem_we || dmem_re) begin
            assert (dmem_addr[31:10] == '0) else begin
                errors++;
                $display("data access at %0t falls outside the data memory, address %h",
                         $time, dmem_addr);
            end
        end
        if (dmem_re) begin
            load_cycles++;
        end
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // instruction encoders
    function automatic word_t rtype(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t addi(input reg_idx_t rd, input reg_idx_t rs1,
                                   input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t lui(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t lw(input reg_idx_t rd, input reg_idx_t rs1,
                                 input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t sw(input reg_idx_t rs2, input reg_idx_t rs1,
                                 input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t jal(input reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t fill_word(input int idx);
        return 32'hA5A5_0000 ^ 32'(idx);
    endfunction

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_word(output word_t v);
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem(input word_t addr, input word_t exp);
        check_eq($sformatf("dmem[%h]", addr), dmem[addr[9:2]], exp);
    endtask

    task automatic clear_memories();
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = addi(5'd0, 5'd0, 12'(i)); // nops that still differ per word
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic emit(input word_t instr);
        imem[load_ptr] = instr;
        load_ptr++;
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t v);
        word_t upper;
        upper = v + 32'h800; // addi sign-extends the low part
        emit(lui(rd, upper[31:12]));
        emit(addi(rd, rd, v[11:0]));
    endtask

    // success code stays below 0x800 so one addi builds it
    task automatic finish_program(input reg_idx_t base, input logic [11:0] imm,
                                  input word_t succ);
        emit(addi(5'd31, 5'd0, succ[11:0]));
        emit(sw(5'd31, base, imm));
    endtask

    task automatic apb_xfer(input logic write, input logic [apb_addr_w-1:0] addr,
                            input word_t wdata, output word_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        check_eq("pready_o", 32'(pready), 32'd1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_addr_w-1:0] addr, input word_t data);
        word_t unused;
        logic  err;
        apb_xfer(1'b1, addr, data, unused, err);
        check_eq("pslverr_o", 32'(err), 32'd0);
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr, output word_t data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_eq("pslverr_o", 32'(err), 32'd0);
    endtask

    task automatic read_check(input logic [apb_addr_w-1:0] addr, input string name,
                              input word_t exp);
        word_t data;
        apb_read(addr, data);
        check_eq(name, data, exp);
    endtask

    task automatic wait_done();
        word_t status;
        status = '0;
        while (!status[1]) begin
            apb_read(reg_status_addr, status);
        end
    endtask

    task automatic run_core(input word_t init_pc, input word_t offset, input word_t succ);
        apb_write(reg_mem_offset_addr, offset);
        apb_write(reg_init_pc_addr, init_pc);
        apb_write(reg_success_addr, succ);
        apb_write(reg_ctrl_addr, 32'd1);
        wait_done();
    endtask

    task automatic test_registers();
        word_t v0;
        word_t v1;
        word_t v2;
        word_t rdata;
        logic  err;
        read_check(reg_ctrl_addr, "prdata_o (ctrl)", '0);
        read_check(reg_mem_offset_addr, "prdata_o (mem_offset)", '0);
        read_check(reg_init_pc_addr, "prdata_o (init_pc)", '0);
        read_check(reg_success_addr, "prdata_o (success)", '0);
        read_check(reg_status_addr, "prdata_o (status)", '0);
        read_check(reg_cycle_addr, "prdata_o (cycle)", '0);
        read_check(reg_final_addr, "prdata_o (final)", '0);
        draw_word(v0);
        draw_word(v1);
        draw_word(v2);
        apb_write(reg_mem_offset_addr, v0);
        apb_write(reg_init_pc_addr, v1);
        apb_write(reg_success_addr, v2);
        apb_write(reg_status_addr, v0); // read-only, must be ignored
        apb_write(reg_cycle_addr, v1);
        apb_write(reg_final_addr, v2);
        read_check(reg_mem_offset_addr, "prdata_o (mem_offset)", v0);
        read_check(reg_init_pc_addr, "prdata_o (init_pc)", v1);
        read_check(reg_success_addr, "prdata_o (success)", v2);
        read_check(reg_status_addr, "prdata_o (status)", '0);
        read_check(reg_cycle_addr, "prdata_o (cycle)", '0);
        read_check(reg_final_addr, "prdata_o (final)", '0);
        apb_xfer(1'b1, 8'h1C, v2, rdata, err);
        check_eq("pslverr_o (unmapped write)", 32'(err), 32'd1);
        apb_xfer(1'b0, 8'h1C, '0, rdata, err);
        check_eq("pslverr_o (unmapped read)", 32'(err), 32'd1);
        check_eq("prdata_o (unmapped read)", rdata, '0);
        read_check(reg_mem_offset_addr, "prdata_o (mem_offset)", v0);
    endtask

    task automatic test_arith();
        word_t a;
        word_t b;
        word_t exp [5];
        draw_word(a);
        draw_word(b);
        clear_memories();
        load_ptr = 'h100 >> 2;
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3)); // add x3, x1, x2
        emit(rtype(7'h20, 5'd1, 5'd3, 3'b000, 5'd4)); // sub x4, x3, x1
        emit(rtype(7'h00, 5'd3, 5'd4, 3'b111, 5'd5)); // and x5, x4, x3
        emit(rtype(7'h00, 5'd2, 5'd5, 3'b110, 5'd6)); // or  x6, x5, x2
        emit(rtype(7'h00, 5'd5, 5'd6, 3'b100, 5'd7)); // xor x7, x6, x5
        exp[0] = a + b;
        exp[1] = exp[0] - a;
        exp[2] = exp[1] & exp[0];
        exp[3] = exp[2] | b;
        exp[4] = exp[3] ^ exp[2];
        for (int i = 4; i >= 0; i--) begin // x7 first so its data comes straight from the xor
            emit(sw(5'(3 + i), 5'd0, 12'(32'h200 + 4 * i)));
        end
        finish_program(5'd0, 12'h2F0, 32'h5A2);
        load_cycles = 0;
        run_core(32'h100, '0, 32'h5A2);
        check_eq("dmem_re_o cycles", 32'(load_cycles), 32'd0); // no loads in this program
        for (int i = 0; i < 5; i++) begin
            check_mem(32'h200 + 32'(4 * i), exp[i]);
        end
        check_mem(32'h2F0, 32'h5A2);
    endtask

    task automatic test_load_store();
        word_t v;
        word_t w;
        draw_word(v);
        draw_word(w);
        clear_memories();
        dmem['h108 >> 2] = w;
        load_ptr = 0;
        load_const(5'd1, v);
        emit(lui(5'd2, 20'h00001)); // base equals mem_offset
        emit(sw(5'd1, 5'd2, 12'h100));
        emit(lw(5'd3, 5'd2, 12'h100));
        emit(addi(5'd4, 5'd3, 12'h001)); // load result used at once
        emit(sw(5'd4, 5'd2, 12'h104));
        emit(lw(5'd5, 5'd2, 12'h108));
        emit(rtype(7'h00, 5'd4, 5'd5, 3'b000, 5'd6));
        emit(sw(5'd6, 5'd2, 12'h10C));
        finish_program(5'd2, 12'h110, 32'h5A3);
        load_cycles = 0;
        run_core('0, 32'h1000, 32'h5A3);
        check_eq("dmem_re_o cycles", 32'(load_cycles), 32'd2); // two lw
        check_mem(32'h100, v);
        check_mem(32'h104, v + 32'd1);
        check_mem(32'h108, w);
        check_mem(32'h10C, w + v + 32'd1);
        check_mem(32'h110, 32'h5A3);
    endtask

    task automatic test_branches();
        word_t jal_pc;
        word_t exp [6];
        clear_memories();
        load_ptr = 'h200 >> 2;
        emit(addi(5'd10, 5'd0, 12'h055)); // marker
        emit(addi(5'd1, 5'd0, 12'd5));
        emit(addi(5'd2, 5'd0, 12'd5));
        emit(addi(5'd3, 5'd0, 12'd7));
        emit(branch(3'b000, 5'd1, 5'd2, 13'd12)); // beq taken
        emit(addi(5'd10, 5'd0, 12'd1));
        emit(addi(5'd10, 5'd0, 12'd2));
        emit(addi(5'd11, 5'd0, 12'd3));
        emit(branch(3'b001, 5'd1, 5'd2, 13'd12)); // bne not taken
        emit(addi(5'd12, 5'd0, 12'd4));
        emit(addi(5'd13, 5'd0, 12'd5));
        emit(branch(3'b001, 5'd1, 5'd3, 13'd12)); // bne taken
        emit(addi(5'd10, 5'd0, 12'd6));
        emit(addi(5'd10, 5'd0, 12'd7));
        emit(branch(3'b000, 5'd1, 5'd3, 13'd12)); // beq not taken
        emit(addi(5'd14, 5'd0, 12'd8));
        jal_pc = 32'(load_ptr * 4);
        emit(jal(5'd15, 21'd12));
        emit(addi(5'd10, 5'd0, 12'd9));
        emit(addi(5'd10, 5'd0, 12'd10));
        for (int i = 0; i < 6; i++) begin
            emit(sw(5'(10 + i), 5'd0, 12'(32'h300 + 4 * i)));
        end
        finish_program(5'd0, 12'h340, 32'h5A4);
        run_core(32'h200, '0, 32'h5A4);
        exp[0] = 32'h55;
        exp[1] = 32'd3;
        exp[2] = 32'd4;
        exp[3] = 32'd5;
        exp[4] = 32'd8;
        exp[5] = jal_pc + 32'd4; // link value
        for (int i = 0; i < 6; i++) begin
            check_mem(32'h300 + 32'(4 * i), exp[i]);
        end
    endtask

    task automatic test_cycle_count();
        int k;
        clear_memories();
        load_ptr = 'h300 >> 2;
        emit(addi(5'd21, 5'd0, 12'h123));
        emit(addi(5'd20, 5'd0, 12'h5A5));
        for (int i = 0; i < 4; i++) begin
            emit(nop_instr);
        end
        k = load_ptr - ('h300 >> 2);
        emit(sw(5'd20, 5'd0, 12'h380));
        emit(sw(5'd21, 5'd0, 12'h384)); // lies past the stop so never stored
        run_core(32'h300, '0, 32'h5A5);
        read_check(reg_cycle_addr, "prdata_o (cycle)", 32'(k + 4));
        read_check(reg_final_addr, "prdata_o (final)", 32'h5A5);
        read_check(reg_status_addr, "prdata_o (status)", 32'h2);
        check_mem(32'h380, 32'h5A5);
        check_mem(32'h384, fill_word('h384 >> 2));
    endtask

    task automatic test_restart();
        int k;
        read_check(reg_status_addr, "prdata_o (status before restart)", 32'h2);
        load_ptr = 'h040 >> 2;
        emit(addi(5'd22, 5'd0, 12'h5A6));
        for (int i = 0; i < 3; i++) begin
            emit(nop_instr);
        end
        k = load_ptr - ('h040 >> 2);
        emit(sw(5'd22, 5'd0, 12'h390));
        apb_write(reg_success_addr, 32'h5A6);
        apb_write(reg_init_pc_addr, 32'h040);
        apb_write(reg_ctrl_addr, 32'd1);
        read_check(reg_status_addr, "prdata_o (status after restart)", 32'h1);
        wait_done();
        read_check(reg_cycle_addr, "prdata_o (cycle)", 32'(k + 4));
        read_check(reg_final_addr, "prdata_o (final)", 32'h5A6);
        check_mem(32'h390, 32'h5A6);
    endtask

    initial begin
        #(num_tests * cycles_per_test * clk_period);
        $display("timeout, the tests did not complete within the cycle budget");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        clear_memories();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        test_registers();
        test_arith();
        test_load_store();
        test_branches();
        test_cycle_count();
        test_restart();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
